// ==== hdl/ddr_pkg.sv ====
// DDR side constants shared by the read pump, the FIFO and the tile writer
// Addresses count 64-bit words, not bytes
// Framebuffer stride assumes a 640 pixel wide, 32 bpp surface
`default_nettype none

package ddr_pkg;

	// Bus geometry
	localparam int DDR_ADDR_W = 29;
	localparam int DDR_DATA_W = 64;

	typedef logic [DDR_ADDR_W-1:0] ddr_addr_t;
	typedef logic [DDR_DATA_W-1:0] ddr_word_t;
	typedef logic [7:0]            burst_t;

	// Tile descriptor: two header words, then the splat records
	localparam int HEADER_WORDS = 2;
	// One record is one read burst
	localparam int SPLAT_WORDS  = 2;
	// Colour bytes sit in the low bits of record word 1
	localparam int REC_COLOR_W  = 32;

	// Read buffering
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

	// Framebuffer writes, one burst per tile row
	localparam int WR_BURST     = 8;
	localparam int FB_STRIDE_QW = 320;

endpackage

`default_nettype wire

// ==== hdl/raster_pkg.sv ====
// Tile geometry and datapath types for the rasterizer
// Tiles are square and a power of two on a side
// Buffer addresses are row major, row in the upper bits
`default_nettype none

package raster_pkg;

	localparam int TILE_DIM    = 16;
	localparam int TILE_PIXELS = TILE_DIM * TILE_DIM;
	localparam int TILE_CW     = $clog2(TILE_DIM);

	typedef logic [2*TILE_CW-1:0] tb_addr_t;

	// One framebuffer pixel, red in the low byte
	typedef struct packed {
		logic [7:0] pad;
		logic [7:0] b;
		logic [7:0] g;
		logic [7:0] r;
	} pixel_t;

	// Matches the record: word 0 in the low 64 bits, colour above
	typedef struct packed {
		logic [7:0]        opacity;
		logic [7:0]        b;
		logic [7:0]        g;
		logic [7:0]        r;
		logic signed [15:0] y1;
		logic signed [15:0] x1;
		logic signed [15:0] y0;
		logic signed [15:0] x0;
	} splat_t;

	// Tile sequencer states
	typedef enum logic [2:0] {
		IDLE,
		FLUSH_WAIT,
		CLEAR,
		PROCESS,
		FLUSH,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

// ==== hdl/tile_buf_if.sv ====
// One port of a tile buffer, a read channel and a write channel
// Read data is valid the cycle after the read address
`timescale 1ns/10ps
`default_nettype none

interface tile_buf_if import raster_pkg::*; ();

	tb_addr_t rd_addr;
	pixel_t   rd_data;
	tb_addr_t wr_addr;
	pixel_t   wr_data;
	logic     wr_en;

	// Buffer bank side
	modport owner (
		input  rd_addr, wr_addr, wr_data, wr_en,
		output rd_data
	);

	// Rasterizer or writer side
	modport user (
		output rd_addr, wr_addr, wr_data, wr_en,
		input  rd_data
	);

endinterface

`default_nettype wire

// ==== hdl/splat_fifo.sv ====
// First word fall through FIFO for DDR read words
// Writes are not gated, the requester must keep space reserved
// Flush drops all content in one cycle
`timescale 1ns/10ps
`default_nettype none

module splat_fifo import ddr_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  ddr_word_t wr_data,
	input  logic      wr_en,
	input  logic      flush,
	output ddr_word_t rd_data,
	output logic      rd_valid,
	input  logic      rd_ack,
	output logic      room
);

	ddr_word_t mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic pop;

	assign pop      = rd_ack && rd_valid;
	assign rd_valid = (count != '0);
	assign rd_data  = mem[rd_ptr];
	// Space for one more full burst
	assign room     = (FIFO_DEPTH - int'(count)) >= SPLAT_WORDS;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Occupancy follows push and pop together
			count <= count + (FIFO_AW+1)'(wr_en) - (FIFO_AW+1)'(pop);
		end
	end

	// Read pump must never overrun the buffer
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> (count != (FIFO_AW+1)'(FIFO_DEPTH)));

endmodule

`default_nettype wire

// ==== hdl/splat_reader.sv ====
// Builds one splat from two consecutive FIFO words
// Holds the splat and stalls the FIFO until it is taken
`timescale 1ns/10ps
`default_nettype none

module splat_reader import ddr_pkg::*, raster_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  ddr_word_t word_data,
	input  logic      word_valid,
	output logic      word_ready,
	output splat_t    splat,
	output logic      splat_valid,
	input  logic      take
);

	// Next word is record word 1
	logic second;
	logic accept;

	assign word_ready = !splat_valid;
	assign accept     = word_valid && word_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			second      <= 1'b0;
			splat_valid <= 1'b0;
		end else begin
			if (take)
				splat_valid <= 1'b0;
			if (accept) begin
				second <= !second;
				if (second)
					splat_valid <= 1'b1;
			end
		end
	end

	// Box from word 0, colour from the low half of word 1
	always_ff @(posedge clk) begin
		if (accept) begin
			if (second)
				splat[$bits(splat_t)-1:DDR_DATA_W] <= word_data[REC_COLOR_W-1:0];
			else
				splat[DDR_DATA_W-1:0] <= word_data;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tile_rasterizer.sv ====
// Blends one splat at constant opacity over its box clipped to the tile
// One pixel per cycle: read, blend register, write back
// Pixels within a splat never repeat, so no read after write hazard
// A splat that misses the tile completes the cycle after start
`timescale 1ns/10ps
`default_nettype none

module tile_rasterizer import raster_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  splat_t      splat,
	input  logic [15:0] tile_px,
	input  logic [15:0] tile_py,
	input  logic        start,
	output logic        done,
	tile_buf_if.user    tb
);

	logic signed [17:0] lx0, lx1, ly0, ly1;
	logic empty;
	splat_t sp;
	logic running;
	logic [TILE_CW-1:0] x, y, cx0, cx1, cy1;
	logic p0_valid, p0_last;
	logic p1_valid, p1_last;
	tb_addr_t p0_addr, p1_addr;
	pixel_t p1_pix;

	// Limit a tile relative coordinate to the tile
	function automatic logic [TILE_CW-1:0] clamp(input logic signed [17:0] v);
		if (v < 0)
			return '0;
		if (v > TILE_DIM - 1)
			return TILE_CW'(TILE_DIM - 1);
		return v[TILE_CW-1:0];
	endfunction

	// src * a + dst * (255 - a), then >> 8
	function automatic logic [7:0] blend(input logic [7:0] s, input logic [7:0] d,
		input logic [7:0] a);
		logic [15:0] sum;
		sum = s * a + d * (8'd255 - a);
		return sum[15:8];
	endfunction

	// Box corners relative to the tile origin
	assign lx0 = $signed({{2{splat.x0[15]}}, splat.x0}) - $signed({2'b00, tile_px});
	assign lx1 = $signed({{2{splat.x1[15]}}, splat.x1}) - $signed({2'b00, tile_px});
	assign ly0 = $signed({{2{splat.y0[15]}}, splat.y0}) - $signed({2'b00, tile_py});
	assign ly1 = $signed({{2{splat.y1[15]}}, splat.y1}) - $signed({2'b00, tile_py});

	// Nothing to draw when the box misses the tile or is inverted
	assign empty = (lx1 < 0) || (ly1 < 0) || (lx0 > TILE_DIM - 1) || (ly0 > TILE_DIM - 1) ||
		(lx0 > lx1) || (ly0 > ly1);

	always_ff @(posedge clk) begin
		if (reset) begin
			running  <= 1'b0;
			p0_valid <= 1'b0;
			p1_valid <= 1'b0;
			done     <= 1'b0;
		end else begin
			p0_valid <= running;
			p1_valid <= p0_valid;
			done     <= (p1_valid && p1_last) || (start && empty);
			if (start)
				running <= !empty;
			else if (running && x == cx1 && y == cy1)
				running <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			sp  <= splat;
			x   <= clamp(lx0);
			y   <= clamp(ly0);
			cx0 <= clamp(lx0);
			cx1 <= clamp(lx1);
			cy1 <= clamp(ly1);
		end else if (running) begin
			// Row walk, left to right then down
			if (x == cx1) begin
				x <= cx0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
		p0_addr    <= {y, x};
		p0_last    <= (x == cx1) && (y == cy1);
		p1_addr    <= p0_addr;
		p1_last    <= p0_last;
		p1_pix.pad <= '0;
		p1_pix.r   <= blend(sp.r, tb.rd_data.r, sp.opacity);
		p1_pix.g   <= blend(sp.g, tb.rd_data.g, sp.opacity);
		p1_pix.b   <= blend(sp.b, tb.rd_data.b, sp.opacity);
	end

	assign tb.rd_addr = {y, x};
	assign tb.wr_addr = p1_addr;
	assign tb.wr_data = p1_pix;
	assign tb.wr_en   = p1_valid;

	// Dispatcher waits for done before the next splat
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		start |-> !running && !p0_valid && !p1_valid);

endmodule

`default_nettype wire

// ==== hdl/tile_buffer_bank.sv ====
// Ping-pong tile buffers
// Rasterizer side reaches the active buffer, writer side the other one
// A clear zeroes the active buffer over exactly TILE_PIXELS cycles
`timescale 1ns/10ps
`default_nettype none

module tile_buffer_bank import raster_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        clear,
	output logic        clearing,
	input  logic        swap,
	tile_buf_if.owner   rast,
	tile_buf_if.owner   wrt
);

	logic active;
	tb_addr_t clr_addr;

	// ============================================================
	// Clear engine and buffer selection
	// ============================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			active   <= 1'b0;
			clearing <= 1'b0;
			clr_addr <= '0;
		end else begin
			if (swap)
				active <= !active;
			if (clear) begin
				clearing <= 1'b1;
				clr_addr <= '0;
			end else if (clearing) begin
				clr_addr <= clr_addr + 1'b1;
				if (clr_addr == tb_addr_t'(TILE_PIXELS - 1))
					clearing <= 1'b0;
			end
		end
	end

	// ============================================================
	// Two RAMs, registered read
	// ============================================================

	for (genvar i = 0; i < 2; i++) begin : g_ram
		pixel_t mem [TILE_PIXELS];
		pixel_t q;
		logic sel;

		assign sel = (active == 1'(i));

		always_ff @(posedge clk) begin
			// Clear overrides the rasterizer write port
			if (sel && (clearing || rast.wr_en))
				mem[clearing ? clr_addr : rast.wr_addr] <= clearing ? '0 : rast.wr_data;
			q <= mem[sel ? rast.rd_addr : wrt.rd_addr];
		end
	end

	assign rast.rd_data = active ? g_ram[1].q : g_ram[0].q;
	assign wrt.rd_data  = active ? g_ram[0].q : g_ram[1].q;

	// Sequencer holds the rasterizer off during a clear
	a_no_rast_clear: assert property (@(posedge clk) disable iff (reset)
		clearing |-> !rast.wr_en);

endmodule

`default_nettype wire

// ==== hdl/tile_writer.sv ====
// Flushes a finished tile to the framebuffer one row at a time
// Each row is fetched into a local buffer, then sent as one burst
// Two pixels per word, even pixel in the low half
// Assumes the tile origin X is even and a row fits one burst
`timescale 1ns/10ps
`default_nettype none

module tile_writer import ddr_pkg::*, raster_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	output logic        running,
	input  logic [15:0] tile_px,
	input  logic [15:0] tile_py,
	input  ddr_addr_t   fb_base,
	tile_buf_if.user    tb,
	output ddr_addr_t   wr_addr,
	output burst_t      wr_burstcnt,
	output ddr_word_t   wr_data,
	output logic        wr_req,
	input  logic        wr_busy
);

	localparam int WIDX_W = $clog2(WR_BURST);

	logic [TILE_CW-1:0] row;
	logic [TILE_CW:0]   col;
	logic [TILE_CW-1:0] col_q;
	logic [WIDX_W-1:0]  widx;
	logic rd_v;
	logic wr_phase;
	logic fetching;
	ddr_word_t row_buf [WR_BURST];

	// Read phase until all pixels of the row are requested
	assign fetching = running && !wr_phase && !col[TILE_CW];

	assign tb.rd_addr = {row, col[TILE_CW-1:0]};
	assign tb.wr_addr = '0;
	assign tb.wr_data = '0;
	assign tb.wr_en   = 1'b0;

	// Row start in the framebuffer, held for the whole burst
	assign wr_addr = fb_base + ddr_addr_t'((32'(tile_py) + 32'(row)) * FB_STRIDE_QW) +
		ddr_addr_t'(tile_px >> 1);
	assign wr_burstcnt = burst_t'(WR_BURST);
	assign wr_data     = row_buf[widx];
	assign wr_req      = wr_phase;

	always_ff @(posedge clk) begin
		col_q <= col[TILE_CW-1:0];
		if (rd_v)
			row_buf[col_q[TILE_CW-1:1]][col_q[0]*$bits(pixel_t) +: $bits(pixel_t)] <= tb.rd_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			running  <= 1'b0;
			wr_phase <= 1'b0;
			rd_v     <= 1'b0;
			row      <= '0;
			col      <= '0;
			widx     <= '0;
		end else begin
			rd_v <= fetching;
			if (start) begin
				running <= 1'b1;
				row     <= '0;
				col     <= '0;
			end else if (fetching) begin
				col <= col + 1'b1;
			end
			// Last pixel of the row landed
			if (rd_v && col_q == '1) begin
				wr_phase <= 1'b1;
				widx     <= '0;
			end
			// One word leaves per cycle without back-pressure
			if (wr_phase && !wr_busy) begin
				widx <= widx + 1'b1;
				if (widx == WIDX_W'(WR_BURST - 1)) begin
					wr_phase <= 1'b0;
					col      <= '0;
					row      <= row + 1'b1;
					if (row == '1)
						running <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tile_sequencer.sv ====
// Tile control: clear, fetch and rasterize splats, then start the flush
// At most one read burst is outstanding, so FIFO room covers it
// A new tile waits in FLUSH_WAIT while the previous flush runs
`timescale 1ns/10ps
`default_nettype none

module tile_sequencer import ddr_pkg::*, raster_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        tile_start,
	input  ddr_addr_t   tile_addr,
	input  logic [15:0] tile_px,
	input  logic [15:0] tile_py,
	input  logic [31:0] tile_splat_count,
	input  ddr_addr_t   fb_base,
	output logic        tile_done,
	output logic        busy,
	output ddr_addr_t   rd_addr,
	output burst_t      rd_burstcnt,
	output logic        rd_req,
	input  logic        rd_ack,
	input  logic        rd_data_valid,
	input  logic        fifo_room,
	output logic        fifo_flush,
	input  logic        splat_valid,
	output logic        take,
	output logic        rast_start,
	input  logic        rast_done,
	output logic [15:0] rast_tile_px,
	output logic [15:0] rast_tile_py,
	output logic        clear,
	input  logic        clearing,
	output logic        swap,
	output logic        wr_start,
	input  logic        wr_running,
	output logic [15:0] wr_tile_px,
	output logic [15:0] wr_tile_py,
	output ddr_addr_t   wr_fb_base
);

	seq_state_t state;
	ddr_addr_t cur_addr;
	ddr_addr_t cur_fb_base;
	logic [31:0] cur_count;
	logic [31:0] req_cnt;
	logic [31:0] done_cnt;
	logic [3:0] outst;
	logic rast_busy;
	logic flush_busy;
	logic issue;

	// Writer counts as busy from its start pulse on
	assign flush_busy = wr_running || wr_start;

	// Read pump condition
	assign issue = (state == PROCESS) && !rd_req && (outst == '0) &&
		(req_cnt != cur_count) && fifo_room;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= IDLE;
			busy       <= 1'b0;
			tile_done  <= 1'b0;
			rd_req     <= 1'b0;
			fifo_flush <= 1'b0;
			take       <= 1'b0;
			rast_start <= 1'b0;
			clear      <= 1'b0;
			swap       <= 1'b0;
			wr_start   <= 1'b0;
			rast_busy  <= 1'b0;
			outst      <= '0;
			req_cnt    <= '0;
			done_cnt   <= '0;
		end else begin
			// Pulses
			tile_done  <= 1'b0;
			fifo_flush <= 1'b0;
			take       <= 1'b0;
			rast_start <= 1'b0;
			clear      <= 1'b0;
			swap       <= 1'b0;
			wr_start   <= 1'b0;

			// ============================================================
			// Read pump
			// ============================================================
			if (rd_req && rd_ack)
				rd_req <= 1'b0;
			if (issue) begin
				rd_addr     <= cur_addr + ddr_addr_t'(HEADER_WORDS) +
					ddr_addr_t'(req_cnt * SPLAT_WORDS);
				rd_burstcnt <= burst_t'(SPLAT_WORDS);
				rd_req      <= 1'b1;
				req_cnt     <= req_cnt + 1'b1;
			end
			// Words requested but not yet returned
			outst <= outst + (issue ? 4'(SPLAT_WORDS) : 4'd0) - 4'(rd_data_valid);

			if (rast_done) begin
				rast_busy <= 1'b0;
				done_cnt  <= done_cnt + 1'b1;
			end

			// ============================================================
			// Tile FSM
			// ============================================================
			case (state)
				IDLE, DONE: begin
					if (tile_start) begin
						busy         <= 1'b1;
						cur_addr     <= tile_addr;
						cur_count    <= tile_splat_count;
						cur_fb_base  <= fb_base;
						rast_tile_px <= tile_px;
						rast_tile_py <= tile_py;
						req_cnt      <= '0;
						done_cnt     <= '0;
						// Drop any stale words
						fifo_flush   <= 1'b1;
						if (flush_busy) begin
							state <= FLUSH_WAIT;
						end else begin
							clear <= 1'b1;
							state <= CLEAR;
						end
					end else if (state == DONE) begin
						busy  <= 1'b0;
						state <= IDLE;
					end
				end
				FLUSH_WAIT: begin
					if (!flush_busy) begin
						clear <= 1'b1;
						state <= CLEAR;
					end
				end
				// Clearing rises one cycle after the pulse
				CLEAR: begin
					if (!clear && !clearing)
						state <= PROCESS;
				end
				PROCESS: begin
					// Dispatch when the rasterizer is idle
					if (splat_valid && !rast_busy) begin
						take       <= 1'b1;
						rast_start <= 1'b1;
						rast_busy  <= 1'b1;
					end
					if (cur_count == '0 || (rast_done && done_cnt == cur_count - 1'b1))
						state <= FLUSH;
				end
				FLUSH: begin
					if (!flush_busy) begin
						wr_tile_px <= rast_tile_px;
						wr_tile_py <= rast_tile_py;
						wr_fb_base <= cur_fb_base;
						wr_start   <= 1'b1;
						swap       <= 1'b1;
						tile_done  <= 1'b1;
						state      <= DONE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Request fields hold until the DDR controller accepts
	a_rd_hold: assert property (@(posedge clk) disable iff (reset)
		rd_req && !rd_ack |=> rd_req && $stable(rd_addr));

endmodule

`default_nettype wire

// ==== hdl/gsplat_core.sv ====
// Gaussian splat tile core
// Splats are axis aligned boxes at constant opacity
// Tile inputs are sampled on the accepted tile_start only
`timescale 1ns/10ps
`default_nettype none

module gsplat_core import ddr_pkg::*, raster_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        tile_start,
	input  ddr_addr_t   tile_addr,
	input  logic [15:0] tile_px,
	input  logic [15:0] tile_py,
	input  logic [31:0] tile_splat_count,
	input  ddr_addr_t   fb_base,
	output logic        tile_done,
	output logic        busy,
	output ddr_addr_t   rd_addr,
	output burst_t      rd_burstcnt,
	output logic        rd_req,
	input  logic        rd_ack,
	input  ddr_word_t   rd_data,
	input  logic        rd_data_valid,
	output ddr_addr_t   wr_addr,
	output burst_t      wr_burstcnt,
	output ddr_word_t   wr_data,
	output logic        wr_req,
	input  logic        wr_busy
);

	ddr_word_t fifo_data;
	logic fifo_valid, fifo_room, fifo_flush, word_ready;
	splat_t splat;
	logic splat_valid, take, rast_start, rast_done;
	logic clear, clearing, swap, wr_start, wr_running;
	logic [15:0] rast_tile_px, rast_tile_py, wr_tile_px, wr_tile_py;
	ddr_addr_t wr_fb_base;

	tile_buf_if rast_tb ();
	tile_buf_if wrt_tb ();

	tile_sequencer i_seq (
		.clk, .reset, .tile_start, .tile_addr, .tile_px, .tile_py, .tile_splat_count,
		.fb_base, .tile_done, .busy, .rd_addr, .rd_burstcnt, .rd_req, .rd_ack,
		.rd_data_valid, .fifo_room, .fifo_flush, .splat_valid, .take, .rast_start,
		.rast_done, .rast_tile_px, .rast_tile_py, .clear, .clearing, .swap, .wr_start,
		.wr_running, .wr_tile_px, .wr_tile_py, .wr_fb_base
	);

	// DDR read data goes straight in
	splat_fifo i_fifo (
		.clk, .reset, .wr_data(rd_data), .wr_en(rd_data_valid), .flush(fifo_flush),
		.rd_data(fifo_data), .rd_valid(fifo_valid), .rd_ack(word_ready), .room(fifo_room)
	);

	splat_reader i_reader (
		.clk, .reset, .word_data(fifo_data), .word_valid(fifo_valid), .word_ready,
		.splat, .splat_valid, .take
	);

	tile_rasterizer i_rast (
		.clk, .reset, .splat, .tile_px(rast_tile_px), .tile_py(rast_tile_py),
		.start(rast_start), .done(rast_done), .tb(rast_tb.user)
	);

	tile_buffer_bank i_bank (
		.clk, .reset, .clear, .clearing, .swap, .rast(rast_tb.owner), .wrt(wrt_tb.owner)
	);

	tile_writer i_writer (
		.clk, .reset, .start(wr_start), .running(wr_running), .tile_px(wr_tile_px),
		.tile_py(wr_tile_py), .fb_base(wr_fb_base), .tb(wrt_tb.user), .wr_addr,
		.wr_burstcnt, .wr_data, .wr_req, .wr_busy
	);

endmodule

`default_nettype wire

// ==== verification/ddr_model.sv ====
// DDR memory model for the tile core testbench
// Reads come from a descriptor memory, writes land in a separate framebuffer array
// Only the low address bits index each array, so keep tests inside both ranges
// Serves one read burst at a time, which matches the single outstanding request
// Random stalls on read acknowledge, read data and wr_busy when stall_en is high
`timescale 1ns/10ps
`default_nettype none

module ddr_model import ddr_pkg::*; (
	input  logic      clk,
	input  logic      stall_en,
	input  ddr_addr_t rd_addr,
	input  burst_t    rd_burstcnt,
	input  logic      rd_req,
	output logic      rd_ack,
	output ddr_word_t rd_data,
	output logic      rd_data_valid,
	input  ddr_addr_t wr_addr,
	input  burst_t    wr_burstcnt,
	input  ddr_word_t wr_data,
	input  logic      wr_req,
	output logic      wr_busy
);

	localparam int RD_AW = 12;
	localparam int FB_AW = 14;

	// Descriptor words, loaded by the testbench
	ddr_word_t rmem [2**RD_AW];
	// Framebuffer, read back by the testbench
	ddr_word_t fb [2**FB_AW];
	int wr_count = 0;

	logic [15:0] lfsr = 16'd73;
	logic filled = 1'b0;
	logic ack_q = 1'b0;
	logic valid_q = 1'b0;
	logic busy_q = 1'b0;
	ddr_word_t data_q = '0;
	ddr_addr_t rd_ptr = '0;
	ddr_addr_t wr_ptr = '0;
	int rd_left = 0;
	int wr_left = 0;
	logic next_ack;
	logic next_valid;
	logic next_busy;
	ddr_word_t next_data;

	assign rd_ack        = ack_q;
	assign rd_data       = data_q;
	assign rd_data_valid = valid_q;
	assign wr_busy       = busy_q;

	// One Galois LFSR step per decision, high bit means go
	function automatic logic proceed();
		if (!stall_en)
			return 1'b1;
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	always @(posedge clk) begin
		// Framebuffer starts with an address pattern so unwritten words show up
		if (!filled) begin
			for (int i = 0; i < 2**FB_AW; i++)
				fb[i] = {~32'(i), 32'(i)};
			filled = 1'b1;
		end

		// ============================================================
		// Write side, sampled at the edge
		// ============================================================
		if (wr_req && !busy_q) begin
			// Address and count belong to the first word
			if (wr_left == 0) begin
				wr_ptr  = wr_addr;
				wr_left = int'(wr_burstcnt);
			end
			fb[wr_ptr[FB_AW-1:0]] = wr_data;
			wr_ptr   = wr_ptr + 1'b1;
			wr_left  = wr_left - 1;
			wr_count = wr_count + 1;
		end

		// ============================================================
		// Read side
		// ============================================================
		next_ack   = 1'b0;
		next_valid = 1'b0;
		next_data  = data_q;
		if (ack_q) begin
			// Request fields are still held in the acknowledge cycle
			rd_ptr  = rd_addr;
			rd_left = int'(rd_burstcnt);
		end else if (rd_req && rd_left == 0 && proceed()) begin
			next_ack = 1'b1;
		end
		if (rd_left > 0 && proceed()) begin
			next_valid = 1'b1;
			next_data  = rmem[rd_ptr[RD_AW-1:0]];
			rd_ptr     = rd_ptr + 1'b1;
			rd_left    = rd_left - 1;
		end
		next_busy = !proceed();

		// Outputs change a little after the edge
		#2;
		ack_q   = next_ack;
		valid_q = next_valid;
		data_q  = next_data;
		busy_q  = next_busy;
	end

endmodule

`default_nettype wire

// ==== verification/gsplat_tb.sv ====
// Directed testbench for the tile core
// Expected framebuffer words come from a reference blend over a 16x16 tile
// Tile origins are multiples of 16 so the flush address stays word aligned
// Stops at the first error
`timescale 1ns/10ps
`default_nettype none

module gsplat_tb import ddr_pkg::*, raster_pkg::*;;

	localparam int FB_BASE = 1024;
	localparam int TIMEOUT = 20000;

	logic clk = 1'b0;
	logic reset;
	logic tile_start;
	ddr_addr_t tile_addr;
	logic [15:0] tile_px;
	logic [15:0] tile_py;
	logic [31:0] tile_splat_count;
	ddr_addr_t fb_base;
	logic tile_done;
	logic busy;
	ddr_addr_t rd_addr;
	burst_t rd_burstcnt;
	logic rd_req;
	logic rd_ack;
	ddr_word_t rd_data;
	logic rd_data_valid;
	ddr_addr_t wr_addr;
	burst_t wr_burstcnt;
	ddr_word_t wr_data;
	logic wr_req;
	logic wr_busy;
	logic stall_en;

	logic [15:0] lfsr;
	// Reference tile contents, one slot per tile in flight
	logic [31:0] ref_pix [2][TILE_PIXELS];

	always #10 clk = ~clk;

	gsplat_core i_dut (
		.clk, .reset, .tile_start, .tile_addr, .tile_px, .tile_py, .tile_splat_count,
		.fb_base, .tile_done, .busy, .rd_addr, .rd_burstcnt, .rd_req, .rd_ack, .rd_data,
		.rd_data_valid, .wr_addr, .wr_burstcnt, .wr_data, .wr_req, .wr_busy
	);

	ddr_model i_ddr (
		.clk, .stall_en, .rd_addr, .rd_burstcnt, .rd_req, .rd_ack, .rd_data,
		.rd_data_valid, .wr_addr, .wr_burstcnt, .wr_data, .wr_req, .wr_busy
	);

	// ============================================================
	// Helpers
	// ============================================================

	// Inputs change and outputs are sampled 2 ns after the edge
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
			abort_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// Per channel blend, source weighted by opacity
	function automatic logic [7:0] mix(input int s, input int d, input int a);
		return 8'((s * a + d * (255 - a)) >> 8);
	endfunction

	task automatic clear_ref(input int slot);
		for (int i = 0; i < TILE_PIXELS; i++)
			ref_pix[slot][i] = '0;
	endtask

	task automatic put_header(input int base, input int count);
		i_ddr.rmem[base] = {32'h7469_6c65, 32'(count)};
		i_ddr.rmem[base + 1] = {~32'(base), 32'(base)};
	endtask

	// Store one record and blend it into the reference tile
	task automatic put_splat(input int slot, input int base, input int idx, input int px,
		input int py, input int x0, input int y0, input int x1, input int y1,
		input logic [31:0] color);
		int gx;
		int gy;
		int a;
		logic [31:0] old;
		i_ddr.rmem[base + HEADER_WORDS + SPLAT_WORDS * idx] =
			{16'(y1), 16'(x1), 16'(y0), 16'(x0)};
		// Upper half of word 1 is junk
		i_ddr.rmem[base + HEADER_WORDS + SPLAT_WORDS * idx + 1] =
			{32'hA5C3_0F96 ^ 32'(idx), color};
		a = int'(color[31:24]);
		for (int ty = 0; ty < TILE_DIM; ty++) begin
			for (int tx = 0; tx < TILE_DIM; tx++) begin
				gx = px + tx;
				gy = py + ty;
				if (gx >= x0 && gx <= x1 && gy >= y0 && gy <= y1) begin
					old = ref_pix[slot][ty * TILE_DIM + tx];
					ref_pix[slot][ty * TILE_DIM + tx] = {8'h00,
						mix(int'(color[23:16]), int'(old[23:16]), a),
						mix(int'(color[15:8]), int'(old[15:8]), a),
						mix(int'(color[7:0]), int'(old[7:0]), a)};
				end
			end
		end
	endtask

	task automatic gen_random_splats(input int slot, input int base, input int px,
		input int py, input int n);
		int x0;
		int y0;
		int x1;
		int y1;
		logic [31:0] color;
		clear_ref(slot);
		put_header(base, n);
		for (int i = 0; i < n; i++) begin
			// Boxes start up to 4 pixels before the tile and may run past it
			x0 = px - 4 + int'(rand_bits(5));
			y0 = py - 4 + int'(rand_bits(5));
			x1 = x0 + int'(rand_bits(4));
			y1 = y0 + int'(rand_bits(4));
			color[15:0] = rand_bits(16);
			color[31:16] = rand_bits(16);
			put_splat(slot, base, i, px, py, x0, y0, x1, y1, color);
		end
	endtask

	// Pulse tile_start, busy must follow one cycle later
	task automatic run_tile(input int addr, input int px, input int py, input int count,
		input string name);
		tile_addr = ddr_addr_t'(addr);
		tile_px = 16'(px);
		tile_py = 16'(py);
		tile_splat_count = 32'(count);
		fb_base = ddr_addr_t'(FB_BASE);
		tile_start = 1'b1;
		tick();
		tile_start = 1'b0;
		compare({name, " busy high"}, 64'd1, 64'(busy));
	endtask

	task automatic wait_tile_done(input string name);
		int n;
		n = 0;
		while (!tile_done) begin
			tick();
			n++;
			if (n > TIMEOUT)
				abort_run({"timeout waiting for tile_done in ", name});
		end
		tick();
		compare({name, " tile_done pulse"}, 64'd0, 64'(tile_done));
		compare({name, " busy low"}, 64'd0, 64'(busy));
	endtask

	// Flush runs in the background, so wait on the number of words written
	task automatic wait_writes(input int target, input string name);
		int n;
		n = 0;
		while (i_ddr.wr_count < target) begin
			tick();
			n++;
			if (n > TIMEOUT)
				abort_run({"timeout waiting for framebuffer writes in ", name});
		end
		repeat (20) tick();
		compare({name, " write count"}, 64'(target), 64'(i_ddr.wr_count));
		compare({name, " wr_req idle"}, 64'd0, 64'(wr_req));
	endtask

	// Even pixel in the low half of each word
	task automatic check_tile(input int slot, input int px, input int py, input string name);
		int addr;
		logic [63:0] exp;
		for (int row = 0; row < TILE_DIM; row++) begin
			for (int w = 0; w < WR_BURST; w++) begin
				addr = FB_BASE + (py + row) * FB_STRIDE_QW + px / 2 + w;
				exp = {ref_pix[slot][row * TILE_DIM + 2 * w + 1],
					ref_pix[slot][row * TILE_DIM + 2 * w]};
				compare($sformatf("%s fb[%0d]", name, addr), exp, i_ddr.fb[addr]);
			end
		end
	endtask

	// ============================================================
	// Tests
	// ============================================================

	task automatic test_reset_state();
		compare("reset_state busy", 64'd0, 64'(busy));
		compare("reset_state tile_done", 64'd0, 64'(tile_done));
		compare("reset_state rd_req", 64'd0, 64'(rd_req));
		compare("reset_state wr_req", 64'd0, 64'(wr_req));
	endtask

	task automatic test_empty_tile();
		int start;
		start = i_ddr.wr_count;
		clear_ref(0);
		put_header(0, 0);
		run_tile(0, 0, 0, 0, "empty_tile");
		wait_tile_done("empty_tile");
		wait_writes(start + TILE_PIXELS / 2, "empty_tile");
		check_tile(0, 0, 0, "empty_tile");
	endtask

	task automatic test_opaque_splat();
		int start;
		start = i_ddr.wr_count;
		clear_ref(0);
		put_header(64, 1);
		put_splat(0, 64, 0, 16, 0, 19, 3, 25, 11, {8'd255, 8'd50, 8'd100, 8'd200});
		run_tile(64, 16, 0, 1, "opaque_splat");
		wait_tile_done("opaque_splat");
		wait_writes(start + TILE_PIXELS / 2, "opaque_splat");
		check_tile(0, 16, 0, "opaque_splat");
		// Row 4, x 18 outside the box and x 19 inside
		compare("opaque_splat left edge", {8'h00, 8'd49, 8'd99, 8'd199, 32'h0},
			i_ddr.fb[FB_BASE + 4 * FB_STRIDE_QW + 8 + 1]);
	endtask

	task automatic test_blend_clip();
		int start;
		start = i_ddr.wr_count;
		clear_ref(0);
		put_header(128, 5);
		put_splat(0, 128, 0, 16, 16, 18, 18, 26, 26, {8'd255, 8'd20, 8'd180, 8'd240});
		put_splat(0, 128, 1, 16, 16, 22, 20, 30, 28, {8'd128, 8'd200, 8'd40, 8'd90});
		// Runs past the top and right edges
		put_splat(0, 128, 2, 16, 16, 28, 10, 40, 24, {8'd200, 8'd77, 8'd130, 8'd15});
		// Wholly outside
		put_splat(0, 128, 3, 16, 16, 100, 100, 110, 110, {8'd255, 8'd255, 8'd255, 8'd255});
		// Negative corner, only the top left 2x2 is inside
		put_splat(0, 128, 4, 16, 16, -5, -5, 17, 17, {8'd64, 8'd10, 8'd250, 8'd160});
		run_tile(128, 16, 16, 5, "blend_clip");
		wait_tile_done("blend_clip");
		wait_writes(start + TILE_PIXELS / 2, "blend_clip");
		check_tile(0, 16, 16, "blend_clip");
	endtask

	task automatic test_random_tiles();
		int start;
		start = i_ddr.wr_count;
		gen_random_splats(0, 256, 32, 0, 12);
		gen_random_splats(1, 512, 0, 32, 12);
		stall_en = 1'b1;
		run_tile(256, 32, 0, 12, "random_tile_a");
		wait_tile_done("random_tile_a");
		// Second tile starts while the first one is still flushing
		run_tile(512, 0, 32, 12, "random_tile_b");
		wait_tile_done("random_tile_b");
		wait_writes(start + TILE_PIXELS, "random_tiles");
		stall_en = 1'b0;
		check_tile(0, 32, 0, "random_tile_a");
		check_tile(1, 0, 32, "random_tile_b");
	endtask

	initial begin
		reset = 1'b1;
		tile_start = 1'b0;
		tile_addr = '0;
		tile_px = '0;
		tile_py = '0;
		tile_splat_count = '0;
		fb_base = '0;
		stall_en = 1'b0;
		lfsr = 16'd73;
		repeat (8) tick();
		reset = 1'b0;
		tick();
		test_reset_state();
		test_empty_tile();
		test_opaque_splat();
		test_blend_clip();
		test_random_tiles();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/ddr_pkg.sv
hdl/raster_pkg.sv
hdl/tile_buf_if.sv
hdl/splat_fifo.sv
hdl/splat_reader.sv
hdl/tile_rasterizer.sv
hdl/tile_buffer_bank.sv
hdl/tile_writer.sv
hdl/tile_sequencer.sv
hdl/gsplat_core.sv
verification/ddr_model.sv
verification/gsplat_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the tile core testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module gsplat_tb -Mdir obj_dir -f build.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build returned status $status"
	exit "$status"
fi

./obj_dir/Vgsplat_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit "$status"
fi
exit 0
